// ==== bench/exec_stage_tb.sv ====
`timescale 1ns/1ps

`include "exec_defs.svh"

module exec_stage_tb
    import exec_pkg::*;
;

    typedef struct packed {
        exec_type_e            op;
        exec_funct3_t          f3;
        exec_alt_e             alt;
        logic [`EXEC_XLEN-1:0] rs1;
        logic [`EXEC_XLEN-1:0] rs2;
        logic [`EXEC_XLEN-1:0] mem;
        logic [`EXEC_XLEN-1:0] imm;
        logic [`EXEC_XLEN-1:0] pc;
        logic [`EXEC_REG_AW-1:0] rd;
        logic [2:0]            reuse; // Order is rs1, rs2, mem.
    } row_t;

    logic clk = 1'b0;
    logic arst_n, cmd_valid, cmd_ready;
    exec_type_e op_type;
    exec_funct3_t funct3;
    exec_alt_e alu_alt;
    logic [`EXEC_XLEN-1:0] rs1_value, rs2_value, mem_value, imm_value, pc;
    logic [`EXEC_REG_AW-1:0] reg_addr;
    logic reuse_rs1, reuse_rs2, reuse_mem;
    logic res_valid, res_ready, mcmd_valid, mcmd_ready, mreq_valid, mreq_ready;
    logic br_valid, br_ready, mreq_rd_en, br_taken;
    logic [`EXEC_REG_AW-1:0] res_reg_addr, mcmd_reg_addr;
    logic [`EXEC_XLEN-1:0] res_value, mreq_addr, mreq_data, br_base, br_rel;
    exec_funct3_t mcmd_ls;
    logic [1:0] mcmd_offset;
    logic [`EXEC_MASK_W-1:0] mreq_wr_en;

    row_t rows[$];
    exec_result_t exp_res[$];
    exec_mem_cmd_t exp_mcmd[$];
    exec_mem_req_t exp_mreq[$];
    exec_branch_t exp_br[$];
    logic [`EXEC_XLEN-1:0] last_exec = '0;
    int value_errors = 0;
    int flow_errors = 0;
    int timeout_errors = 0;

    exec_stage exec_stage_inst (.*);

    always #5 clk = ~clk;

    initial begin : drive_readies
        {res_ready, mcmd_ready, mreq_ready, br_ready} = '0;
        void'($urandom(43680));
        forever begin
            @(negedge clk);
            res_ready  = ($urandom % 10) < 7; // Roughly 70 percent of cycles accept.
            mcmd_ready = ($urandom % 10) < 7;
            mreq_ready = ($urandom % 10) < 7;
            br_ready   = ($urandom % 10) < 7;
        end
    end

    function automatic void add_row(input exec_type_e op, input exec_funct3_t f3,
                                    input exec_alt_e alt, input logic [31:0] rs1,
                                    input logic [31:0] rs2, input logic [31:0] mem,
                                    input logic [31:0] imm, input logic [4:0] rd,
                                    input logic [2:0] reuse);
        row_t r;
        r = '{op, f3, alt, rs1, rs2, mem, imm, 32'h0000_8000 + 4 * rows.size(), rd, reuse};
        rows.push_back(r);
    endfunction

    // Expected outputs follow the RV32I meaning of each operation.
    function automatic void predict(input row_t r);
        logic [31:0] a, b, c, addr, val;
        logic [3:0] lanes;
        logic taken;
        exec_result_t er;
        exec_mem_cmd_t emc;
        exec_mem_req_t emr;
        exec_branch_t eb;
        a = r.reuse[2] ? last_exec : r.rs1;
        b = r.reuse[1] ? last_exec : r.rs2;
        c = r.reuse[0] ? last_exec : r.mem;
        addr = a + b;
        case (r.op)
            EXECUTE: begin
                case (r.f3)
                    F3_ALU_ADD_SUB: val = (r.alt == ALTERNATE) ? a - b : a + b;
                    F3_ALU_SLL:     val = a << b[4:0];
                    F3_ALU_SLT:     val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    F3_ALU_SLTU:    val = (a < b) ? 32'd1 : 32'd0;
                    F3_ALU_XOR:     val = a ^ b;
                    F3_ALU_OR:      val = a | b;
                    F3_ALU_AND:     val = a & b;
                    default: begin
                        if (r.alt == ALTERNATE) val = $signed(a) >>> b[4:0];
                        else val = a >> b[4:0];
                    end
                endcase
                er = '{r.rd, val};
                exp_res.push_back(er);
                last_exec = val;
            end
            LOAD: begin
                emc = '{r.rd, r.f3, addr[1:0]};
                exp_mcmd.push_back(emc);
                emr = '{1'b1, 4'b0000, addr, 32'h0};
                exp_mreq.push_back(emr);
            end
            STORE: begin
                lanes = (r.f3 == F3_LS_B) ? 4'b0001 : (r.f3 == F3_LS_H) ? 4'b0011 : 4'b1111;
                lanes = lanes << addr[1:0];
                val = c << (8 * addr[1:0]);
                emr = '{1'b0, lanes, addr, val};
                exp_mreq.push_back(emr);
            end
            default: begin
                case (r.f3)
                    F3_BR_BEQ:  taken = (a == b);
                    F3_BR_BNE:  taken = (a != b);
                    F3_BR_BLT:  taken = $signed(a) < $signed(b);
                    F3_BR_BGE:  taken = $signed(a) >= $signed(b);
                    F3_BR_BLTU: taken = a < b;
                    default:    taken = a >= b;
                endcase
                eb = '{taken, r.pc, r.imm};
                exp_br.push_back(eb);
            end
        endcase
    endfunction

    always @(posedge clk) begin : check_outputs
        exec_result_t e_res;
        exec_mem_cmd_t e_mcmd;
        exec_mem_req_t e_mreq;
        exec_branch_t e_br;
        if (arst_n && res_valid && res_ready) begin
            if (exp_res.size() == 0) begin
                $display("Unexpected result output at %0t.", $time);
                flow_errors++;
            end else begin
                e_res = exp_res.pop_front();
                if (res_reg_addr !== e_res.reg_addr || res_value !== e_res.value) begin
                    $display("FAILED at %0t: result rd=%0d value=%h, expected rd=%0d value=%h",
                             $time, res_reg_addr, res_value, e_res.reg_addr, e_res.value);
                    value_errors++;
                end
            end
        end
        if (arst_n && mcmd_valid && mcmd_ready) begin
            if (exp_mcmd.size() == 0) begin
                $display("Unexpected memory command at %0t.", $time);
                flow_errors++;
            end else begin
                e_mcmd = exp_mcmd.pop_front();
                if ({mcmd_reg_addr, mcmd_ls, mcmd_offset} !== e_mcmd) begin
                    $display("FAILED at %0t: memory command %h, expected %h",
                             $time, {mcmd_reg_addr, mcmd_ls, mcmd_offset}, e_mcmd);
                    value_errors++;
                end
            end
        end
        if (arst_n && mreq_valid && mreq_ready) begin
            if (exp_mreq.size() == 0) begin
                $display("Unexpected memory request at %0t.", $time);
                flow_errors++;
            end else begin
                e_mreq = exp_mreq.pop_front();
                if (mreq_rd_en !== e_mreq.rd_en || mreq_wr_en !== e_mreq.wr_en ||
                    mreq_addr !== e_mreq.addr ||
                    (!e_mreq.rd_en && mreq_data !== e_mreq.data)) begin
                    $display("FAILED at %0t: memory request rd=%b we=%b addr=%h data=%h",
                             $time, mreq_rd_en, mreq_wr_en, mreq_addr, mreq_data);
                    $display("    expected rd=%b we=%b addr=%h data=%h",
                             e_mreq.rd_en, e_mreq.wr_en, e_mreq.addr, e_mreq.data);
                    value_errors++;
                end
            end
        end
        if (arst_n && br_valid && br_ready) begin
            if (exp_br.size() == 0) begin
                $display("Unexpected branch output at %0t.", $time);
                flow_errors++;
            end else begin
                e_br = exp_br.pop_front();
                if ({br_taken, br_base, br_rel} !== e_br) begin
                    $display("FAILED at %0t: branch taken=%b base=%h rel=%h, expected %h",
                             $time, br_taken, br_base, br_rel, e_br);
                    value_errors++;
                end
            end
        end
    end

    initial begin
        int wait_cnt;
        bit accepted;
        bit timed_out;
        row_t cur;
        timed_out = 1'b0;
        {arst_n, cmd_valid, reuse_rs1, reuse_rs2, reuse_mem} = '0;
        {rs1_value, rs2_value, mem_value, imm_value, pc, reg_addr} = '0;
        op_type = EXECUTE;
        funct3 = '0;
        alu_alt = NORMAL;

        add_row(EXECUTE, F3_ALU_ADD_SUB, NORMAL,    32'h0000_1234, 32'h0000_0f0f, 0, 0, 1, 0);
        add_row(EXECUTE, F3_ALU_ADD_SUB, ALTERNATE, 32'd5,         32'd7,         0, 0, 2, 0);
        add_row(EXECUTE, F3_ALU_SLL,     NORMAL,    32'h8000_0001, 32'h0000_0024, 0, 0, 3, 0);
        add_row(EXECUTE, F3_ALU_SLT,     NORMAL,    32'hffff_fffd, 32'd2,         0, 0, 4, 0);
        add_row(EXECUTE, F3_ALU_SLTU,    NORMAL,    32'hffff_fffd, 32'd2,         0, 0, 5, 0);
        add_row(EXECUTE, F3_ALU_XOR,     NORMAL,    32'hdead_beef, 32'h0ff0_0ff0, 0, 0, 6, 0);
        add_row(EXECUTE, F3_ALU_SRL_SRA, NORMAL,    32'hf000_0000, 32'd8,         0, 0, 7, 0);
        add_row(EXECUTE, F3_ALU_SRL_SRA, ALTERNATE, 32'hf000_0000, 32'd8,         0, 0, 8, 0);
        add_row(EXECUTE, F3_ALU_OR,      NORMAL,    32'h1200_0034, 32'h0056_7800, 0, 0, 9, 0);
        add_row(EXECUTE, F3_ALU_AND,     NORMAL,    32'hff00_ff00, 32'h0f0f_0f0f, 0, 0, 10, 0);
        add_row(LOAD,    F3_LS_W,        NORMAL,    32'h0000_1000, 32'h10, 0, 0, 11, 0);
        add_row(LOAD,    F3_LS_BU,       NORMAL,    32'h0000_2001, 32'h2,  0, 0, 12, 0);
        add_row(STORE,   F3_LS_B,        NORMAL,    32'h0000_3000, 32'h1, 32'h0000_00ab, 0, 0, 0);
        add_row(STORE,   F3_LS_H,        NORMAL,    32'h0000_3000, 32'h2, 32'h0000_1234, 0, 0, 0);
        add_row(STORE,   F3_LS_W,        NORMAL,    32'h0000_3004, 32'h0, 32'hcafe_f00d, 0, 0, 0);
        add_row(STORE,   F3_LS_B,        NORMAL,    32'h0000_3000, 32'h3, 32'h0000_005a, 0, 0, 0);
        add_row(STORE,   F3_LS_B,        NORMAL,    32'h0000_3000, 32'h0, 32'h0000_0011, 0, 0, 0);
        add_row(STORE,   F3_LS_B,        NORMAL,    32'h0000_3000, 32'h2, 32'h0000_0022, 0, 0, 0);
        add_row(STORE,   F3_LS_H,        NORMAL,    32'h0000_3000, 32'h0, 32'h0000_5678, 0, 0, 0);
        add_row(BRANCH,  F3_BR_BEQ,  NORMAL, 32'd9,         32'd9, 0, 32'h40,        0, 0);
        add_row(BRANCH,  F3_BR_BNE,  NORMAL, 32'd9,         32'd9, 0, 32'h80,        0, 0);
        add_row(BRANCH,  F3_BR_BLT,  NORMAL, 32'hffff_ffff, 32'd1, 0, 32'hffff_fff0, 0, 0);
        add_row(BRANCH,  F3_BR_BGE,  NORMAL, 32'hffff_ffff, 32'd1, 0, 32'h10,        0, 0);
        add_row(BRANCH,  F3_BR_BLTU, NORMAL, 32'hffff_ffff, 32'd1, 0, 32'h20,        0, 0);
        add_row(BRANCH,  F3_BR_BGEU, NORMAL, 32'hffff_ffff, 32'd1, 0, 32'h30,        0, 0);
        add_row(BRANCH,  F3_BR_BEQ,  NORMAL, 32'd0, 32'd1, 0, 32'h44, 0, 3'b110); // Both forwarded.
        add_row(LOAD,    F3_LS_H,        NORMAL, 32'd0, 32'h3,   0, 0, 13, 3'b100);
        add_row(STORE,   F3_LS_W,        NORMAL, 32'h4000, 32'h0, 0, 0, 0, 3'b001);
        add_row(EXECUTE, F3_ALU_ADD_SUB, NORMAL, 32'd0, 32'h100, 0, 0, 14, 3'b100);

        repeat (10) @(posedge clk);
        @(negedge clk);
        if ({res_valid, mcmd_valid, mreq_valid, br_valid} !== 4'b0000) begin
            $display("An output valid is not low after reset.");
            flow_errors++;
        end
        arst_n = 1'b1;

        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            @(negedge clk);
            cur = rows[i];
            op_type   = cur.op;
            funct3    = cur.f3;
            alu_alt   = cur.alt;
            rs1_value = cur.rs1;
            rs2_value = cur.rs2;
            mem_value = cur.mem;
            imm_value = cur.imm;
            pc        = cur.pc;
            reg_addr  = cur.rd;
            {reuse_rs1, reuse_rs2, reuse_mem} = cur.reuse;
            cmd_valid = 1'b1;
            predict(cur);
            accepted = 1'b0;
            wait_cnt = 0;
            while (!accepted && !timed_out) begin
                @(posedge clk);
                if (cmd_ready) begin
                    accepted = 1'b1;
                end else begin
                    wait_cnt++;
                    if (wait_cnt > 100) begin
                        $display("Timeout: row %0d was not accepted within 100 cycles.", i);
                        timeout_errors++;
                        timed_out = 1'b1;
                    end
                end
            end
        end
        @(negedge clk);
        cmd_valid = 1'b0;

        wait_cnt = 0;
        while ((exp_res.size() + exp_mcmd.size() + exp_mreq.size() + exp_br.size() != 0 ||
                res_valid || mcmd_valid || mreq_valid || br_valid) && wait_cnt < 200) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (exp_res.size() + exp_mcmd.size() + exp_mreq.size() + exp_br.size() != 0) begin
            $display("Outputs missing at the end: %0d result, %0d command, %0d request, %0d branch.",
                     exp_res.size(), exp_mcmd.size(), exp_mreq.size(), exp_br.size());
            flow_errors++;
        end
        if (res_valid || mcmd_valid || mreq_valid || br_valid) begin
            $display("An output valid is still high after every expected output has transferred.");
            flow_errors++;
        end

        $display("Errors: %0d wrong values, %0d missing or unexpected outputs, %0d timeouts",
                 value_errors, flow_errors, timeout_errors);
        if (value_errors + flow_errors + timeout_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== design/exec_alu.sv ====
`timescale 1ns/1ps

`include "exec_defs.svh"

module exec_alu
    import exec_pkg::*;
(
    input  logic [`EXEC_XLEN-1:0] a,
    input  logic [`EXEC_XLEN-1:0] b,
    input  exec_alt_e             alt,
    output exec_math_t            math
);

    localparam int SHAMT_W = $clog2(`EXEC_XLEN);

    logic [SHAMT_W-1:0]          shamt;
    logic [`EXEC_XLEN-1:0]       sum;
    logic [`EXEC_XLEN-1:0]       diff;
    logic [`EXEC_XLEN-1:0]       srl_res;
    logic signed [`EXEC_XLEN-1:0] sra_res;
    logic                        lt_signed;
    logic                        lt_unsigned;

    assign shamt = b[SHAMT_W-1:0]; // Only the low bits of b count as a shift amount.

    assign sum  = a + b;
    assign diff = a - b;

    assign srl_res = a >> shamt;
    assign sra_res = $signed(a) >>> shamt; // Signed on both sides keeps the sign fill.

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        if (alt == ALTERNATE) begin
            math.add_sub = diff;
            math.rshift  = sra_res;
        end else begin
            math.add_sub = sum;
            math.rshift  = srl_res;
        end

        math.lshift = a << shamt;
        math.xor_r  = a ^ b;
        math.or_r   = a | b;
        math.and_r  = a & b;

        // Equality does not depend on the variant.
        math.eq = (a == b);

        if (alt == ALTERNATE) begin
            math.lt = lt_signed;
        end else begin
            math.lt = lt_unsigned;
        end

        math.ltu = lt_unsigned; // SLTU and the unsigned branches use this one.
    end

endmodule

// ==== design/exec_defs.svh ====
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Data path and address width of the execute stage.
`define EXEC_XLEN 32

// Register file address width, enough for x0 to x31.
`define EXEC_REG_AW 5

// One enable bit per byte lane of a store.
`define EXEC_MASK_W 4

`endif

// ==== design/exec_flow_ctrl.sv ====
`timescale 1ns/1ps

module exec_flow_ctrl
    import exec_pkg::*;
(
    input  logic       cmd_valid,
    input  logic [3:0] produce,
    input  logic [3:0] busy,
    output logic       cmd_ready,
    output logic [3:0] load
);

    logic any_busy;
    logic take;
    logic load_res;
    logic load_mcmd;
    logic load_mreq;
    logic load_br;

    // All four slices gate the input, even those this operation leaves alone.
    assign any_busy = |busy;

    assign cmd_ready = !any_busy;

    assign take = cmd_valid && cmd_ready; // The operation transfers on this edge.

    assign load_res  = take && produce[PROD_RES];
    assign load_mcmd = take && produce[PROD_MCMD];
    assign load_mreq = take && produce[PROD_MREQ];
    assign load_br   = take && produce[PROD_BR];

    always_comb begin
        load            = '0;
        load[PROD_RES]  = load_res;
        load[PROD_MCMD] = load_mcmd;
        load[PROD_MREQ] = load_mreq;
        load[PROD_BR]   = load_br;
    end

endmodule

// ==== design/exec_op_select.sv ====
`timescale 1ns/1ps

`include "exec_defs.svh"

module exec_op_select
    import exec_pkg::*;
(
    input  exec_type_e              op_type,
    input  exec_funct3_t            funct3,
    input  exec_alt_e               alu_alt,
    input  logic [`EXEC_XLEN-1:0]   rs1_value,
    input  logic [`EXEC_XLEN-1:0]   rs2_value,
    input  logic [`EXEC_XLEN-1:0]   mem_value,
    input  logic [`EXEC_XLEN-1:0]   imm_value,
    input  logic [`EXEC_XLEN-1:0]   pc,
    input  logic [`EXEC_REG_AW-1:0] reg_addr,
    input  logic                    reuse_rs1,
    input  logic                    reuse_rs2,
    input  logic                    reuse_mem,
    input  logic [`EXEC_XLEN-1:0]   fwd_value,
    output exec_result_t            next_res,
    output exec_mem_cmd_t           next_mcmd,
    output exec_mem_req_t           next_mreq,
    output exec_branch_t            next_br,
    output logic [3:0]              produce
);

    logic [`EXEC_XLEN-1:0]   op_a;
    logic [`EXEC_XLEN-1:0]   op_b;
    logic [`EXEC_XLEN-1:0]   op_c;
    exec_alt_e               alt;
    exec_math_t              math;
    logic [`EXEC_XLEN-1:0]   st_wdata;
    logic [`EXEC_MASK_W-1:0] st_mask;

    assign op_a = reuse_rs1 ? fwd_value : rs1_value;
    assign op_b = reuse_rs2 ? fwd_value : rs2_value;
    assign op_c = reuse_mem ? fwd_value : mem_value;

    always_comb begin
        case (op_type)
            EXECUTE: begin
                // SLT needs the signed compare, so it rides on ALTERNATE.
                if (funct3 == F3_ALU_ADD_SUB || funct3 == F3_ALU_SRL_SRA) begin
                    alt = alu_alt;
                end else begin
                    alt = ALTERNATE;
                end
            end
            BRANCH:  alt = ALTERNATE;
            default: alt = NORMAL; // Address generation is a plain add.
        endcase
    end

    exec_alu exec_alu_inst (
        .a    (op_a),
        .b    (op_b),
        .alt  (alt),
        .math (math)
    );

    exec_store_align exec_store_align_inst (
        .data   (op_c),
        .offset (math.add_sub[1:0]),
        .ls     (funct3),
        .wdata  (st_wdata),
        .mask   (st_mask)
    );

    always_comb begin
        next_res.reg_addr = reg_addr;
        case (funct3)
            F3_ALU_ADD_SUB: next_res.value = math.add_sub;
            F3_ALU_SLL:     next_res.value = math.lshift;
            F3_ALU_SLT:     next_res.value = {{(`EXEC_XLEN-1){1'b0}}, math.lt};
            F3_ALU_SLTU:    next_res.value = {{(`EXEC_XLEN-1){1'b0}}, math.ltu};
            F3_ALU_XOR:     next_res.value = math.xor_r;
            F3_ALU_SRL_SRA: next_res.value = math.rshift;
            F3_ALU_OR:      next_res.value = math.or_r;
            default:        next_res.value = math.and_r;
        endcase

        next_mcmd.reg_addr = reg_addr;
        next_mcmd.ls       = funct3;
        next_mcmd.offset   = math.add_sub[1:0]; // The alignment stage needs this later.

        next_mreq.rd_en = (op_type == LOAD);
        next_mreq.wr_en = (op_type == STORE) ? st_mask : '0;
        next_mreq.addr  = math.add_sub;
        next_mreq.data  = (op_type == STORE) ? st_wdata : '0;

        case (funct3)
            F3_BR_BEQ:  next_br.taken = math.eq;
            F3_BR_BNE:  next_br.taken = !math.eq;
            F3_BR_BLT:  next_br.taken = math.lt;
            F3_BR_BGE:  next_br.taken = !math.lt;
            F3_BR_BLTU: next_br.taken = math.ltu;
            F3_BR_BGEU: next_br.taken = !math.ltu;
            default:    next_br.taken = 1'b0;
        endcase
        next_br.base_addr = pc;
        next_br.rel_addr  = imm_value;
    end

    always_comb begin
        produce            = '0;
        produce[PROD_RES]  = (op_type == EXECUTE);
        produce[PROD_MCMD] = (op_type == LOAD);
        produce[PROD_MREQ] = (op_type == LOAD) || (op_type == STORE);
        produce[PROD_BR]   = (op_type == BRANCH);
    end

endmodule

// ==== design/exec_out_reg.sv ====
`timescale 1ns/1ps

module exec_out_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     load,
    input  payload_t d,
    input  logic     ready,
    output logic     valid,
    output logic     busy,
    output payload_t q
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1; // A load wins over a transfer in the same cycle.
        end else if (ready) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            q <= d;
        end
    end

    // A slice that drains this cycle may be refilled at once.
    assign busy = valid && !ready;

endmodule

// ==== design/exec_pkg.sv ====
`include "exec_defs.svh"

package exec_pkg;

    typedef enum logic [1:0] {
        EXECUTE = 2'd0,
        LOAD    = 2'd1,
        STORE   = 2'd2,
        BRANCH  = 2'd3
    } exec_type_e;

    // ALTERNATE picks SUB, SRA and the signed compare.
    typedef enum logic {
        NORMAL    = 1'b0,
        ALTERNATE = 1'b1
    } exec_alt_e;

    typedef logic [2:0] exec_funct3_t;

    localparam exec_funct3_t F3_ALU_ADD_SUB = 3'b000;
    localparam exec_funct3_t F3_ALU_SLL     = 3'b001;
    localparam exec_funct3_t F3_ALU_SLT     = 3'b010;
    localparam exec_funct3_t F3_ALU_SLTU    = 3'b011;
    localparam exec_funct3_t F3_ALU_XOR     = 3'b100;
    localparam exec_funct3_t F3_ALU_SRL_SRA = 3'b101;
    localparam exec_funct3_t F3_ALU_OR      = 3'b110;
    localparam exec_funct3_t F3_ALU_AND     = 3'b111;

    localparam exec_funct3_t F3_LS_B  = 3'b000;
    localparam exec_funct3_t F3_LS_H  = 3'b001;
    localparam exec_funct3_t F3_LS_W  = 3'b010;
    localparam exec_funct3_t F3_LS_BU = 3'b100;
    localparam exec_funct3_t F3_LS_HU = 3'b101;

    localparam exec_funct3_t F3_BR_BEQ  = 3'b000;
    localparam exec_funct3_t F3_BR_BNE  = 3'b001;
    localparam exec_funct3_t F3_BR_BLT  = 3'b100;
    localparam exec_funct3_t F3_BR_BGE  = 3'b101;
    localparam exec_funct3_t F3_BR_BLTU = 3'b110;
    localparam exec_funct3_t F3_BR_BGEU = 3'b111;

    // Bit positions of the produce, busy and load vectors.
    localparam int PROD_RES  = 0;
    localparam int PROD_MCMD = 1;
    localparam int PROD_MREQ = 2;
    localparam int PROD_BR   = 3;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0] add_sub;
        logic [`EXEC_XLEN-1:0] lshift;
        logic [`EXEC_XLEN-1:0] rshift;
        logic [`EXEC_XLEN-1:0] xor_r;
        logic [`EXEC_XLEN-1:0] or_r;
        logic [`EXEC_XLEN-1:0] and_r;
        logic                  eq;
        logic                  lt;
        logic                  ltu;
    } exec_math_t;

    typedef struct packed {
        logic [`EXEC_REG_AW-1:0] reg_addr;
        logic [`EXEC_XLEN-1:0]   value;
    } exec_result_t;

    typedef struct packed {
        logic [`EXEC_REG_AW-1:0] reg_addr;
        exec_funct3_t            ls;
        logic [1:0]              offset;
    } exec_mem_cmd_t;

    typedef struct packed {
        logic                    rd_en;
        logic [`EXEC_MASK_W-1:0] wr_en;
        logic [`EXEC_XLEN-1:0]   addr;
        logic [`EXEC_XLEN-1:0]   data;
    } exec_mem_req_t;

    typedef struct packed {
        logic                  taken;
        logic [`EXEC_XLEN-1:0] base_addr;
        logic [`EXEC_XLEN-1:0] rel_addr;
    } exec_branch_t;

endpackage

// ==== design/exec_stage.sv ====
`timescale 1ns/1ps

`include "exec_defs.svh"

module exec_stage
    import exec_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  exec_type_e              op_type,
    input  exec_funct3_t            funct3,
    input  exec_alt_e               alu_alt,
    input  logic [`EXEC_XLEN-1:0]   rs1_value,
    input  logic [`EXEC_XLEN-1:0]   rs2_value,
    input  logic [`EXEC_XLEN-1:0]   mem_value,
    input  logic [`EXEC_XLEN-1:0]   imm_value,
    input  logic [`EXEC_XLEN-1:0]   pc,
    input  logic [`EXEC_REG_AW-1:0] reg_addr,
    input  logic                    reuse_rs1,
    input  logic                    reuse_rs2,
    input  logic                    reuse_mem,

    output logic                    res_valid,
    input  logic                    res_ready,
    output logic [`EXEC_REG_AW-1:0] res_reg_addr,
    output logic [`EXEC_XLEN-1:0]   res_value,

    output logic                    mcmd_valid,
    input  logic                    mcmd_ready,
    output logic [`EXEC_REG_AW-1:0] mcmd_reg_addr,
    output exec_funct3_t            mcmd_ls,
    output logic [1:0]              mcmd_offset,

    output logic                    mreq_valid,
    input  logic                    mreq_ready,
    output logic                    mreq_rd_en,
    output logic [`EXEC_MASK_W-1:0] mreq_wr_en,
    output logic [`EXEC_XLEN-1:0]   mreq_addr,
    output logic [`EXEC_XLEN-1:0]   mreq_data,

    output logic                    br_valid,
    input  logic                    br_ready,
    output logic                    br_taken,
    output logic [`EXEC_XLEN-1:0]   br_base,
    output logic [`EXEC_XLEN-1:0]   br_rel
);

    exec_result_t  next_res, res_q;
    exec_mem_cmd_t next_mcmd, mcmd_q;
    exec_mem_req_t next_mreq, mreq_q;
    exec_branch_t  next_br, br_q;
    logic [3:0]    produce;
    logic [3:0]    busy;
    logic [3:0]    load;

    exec_op_select exec_op_select_inst (
        .op_type, .funct3, .alu_alt,
        .rs1_value, .rs2_value, .mem_value, .imm_value, .pc, .reg_addr,
        .reuse_rs1, .reuse_rs2, .reuse_mem,
        .fwd_value (res_q.value), // Held until the next EXECUTE, so forwarding outlives the transfer.
        .next_res, .next_mcmd, .next_mreq, .next_br, .produce
    );

    exec_flow_ctrl exec_flow_ctrl_inst (
        .cmd_valid, .produce, .busy, .cmd_ready, .load
    );

    exec_out_reg #(.payload_t(exec_result_t)) res_reg_inst (
        .clk, .arst_n, .load (load[PROD_RES]), .d (next_res), .ready (res_ready),
        .valid (res_valid), .busy (busy[PROD_RES]), .q (res_q)
    );

    exec_out_reg #(.payload_t(exec_mem_cmd_t)) mcmd_reg_inst (
        .clk, .arst_n, .load (load[PROD_MCMD]), .d (next_mcmd), .ready (mcmd_ready),
        .valid (mcmd_valid), .busy (busy[PROD_MCMD]), .q (mcmd_q)
    );

    exec_out_reg #(.payload_t(exec_mem_req_t)) mreq_reg_inst (
        .clk, .arst_n, .load (load[PROD_MREQ]), .d (next_mreq), .ready (mreq_ready),
        .valid (mreq_valid), .busy (busy[PROD_MREQ]), .q (mreq_q)
    );

    exec_out_reg #(.payload_t(exec_branch_t)) br_reg_inst (
        .clk, .arst_n, .load (load[PROD_BR]), .d (next_br), .ready (br_ready),
        .valid (br_valid), .busy (busy[PROD_BR]), .q (br_q)
    );

    assign res_reg_addr  = res_q.reg_addr;
    assign res_value     = res_q.value;
    assign mcmd_reg_addr = mcmd_q.reg_addr;
    assign mcmd_ls       = mcmd_q.ls;
    assign mcmd_offset   = mcmd_q.offset;
    assign mreq_rd_en    = mreq_q.rd_en;
    assign mreq_wr_en    = mreq_q.wr_en;
    assign mreq_addr     = mreq_q.addr;
    assign mreq_data     = mreq_q.data;
    assign br_taken      = br_q.taken;
    assign br_base       = br_q.base_addr;
    assign br_rel        = br_q.rel_addr;

endmodule

// ==== design/exec_store_align.sv ====
`timescale 1ns/1ps

`include "exec_defs.svh"

module exec_store_align
    import exec_pkg::*;
(
    input  logic [`EXEC_XLEN-1:0]   data,
    input  logic [1:0]              offset,
    input  exec_funct3_t            ls,
    output logic [`EXEC_XLEN-1:0]   wdata,
    output logic [`EXEC_MASK_W-1:0] mask
);

    logic [`EXEC_MASK_W-1:0] base_mask;

    // The byte offset moves the lowest byte of data to its lane.
    assign wdata = data << {offset, 3'b000};

    always_comb begin
        case (ls)
            F3_LS_B: begin
                base_mask = 4'b0001;
            end
            F3_LS_H: begin
                base_mask = 4'b0011;
            end
            default: begin
                base_mask = 4'b1111; // SW, and anything wider.
            end
        endcase
    end

    // Lanes above bit 3 fall off, as the core never issues misaligned stores.
    assign mask = base_mask << offset;

endmodule

// ==== sim.f ====
+incdir+design
design/exec_pkg.sv
design/exec_alu.sv
design/exec_store_align.sv
design/exec_op_select.sv
design/exec_flow_ctrl.sv
design/exec_out_reg.sv
design/exec_stage.sv
bench/exec_stage_tb.sv
